//--- flist.f
src/scratchpad_pkg.sv
src/dual_port_bram.sv
src/store_align.sv
src/load_align.sv
src/scratchpad_ctrl.sv
src/scratchpad_top.sv
tests/tb_clock.sv
tests/scratchpad_tb.sv

//--- tests/scratchpad_tb.sv
`timescale 1ns/10ps

module scratchpad_tb
    import scratchpad_pkg::*;
();

    localparam int ADDR_W        = 6;
    localparam int RANDOM_REQS   = 400;
    localparam int DIRECTED_REQS = 27;
    localparam int CYCLE_LIMIT   = 2 * (2 * RANDOM_REQS + DIRECTED_REQS) + 200;

    logic       clk, reset_reg;
    logic       fetch_req_valid, fetch_req_ready, fetch_resp_valid, fetch_resp_ready;
    logic       data_req_valid, data_req_ready, data_resp_valid, data_resp_ready;
    fetch_req_t fetch_req;
    data_req_t  data_req;
    resp_t      fetch_resp, data_resp;

    logic [31:0] lfsr = 32'h40c08f90;
    byte_t       model_mem [4 << ADDR_W];
    byte_addr_t  fetch_q [$];
    data_req_t   data_q [$];
    word_t       fetch_exp [$];
    word_t       data_exp [$];
    int          cycles = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    tb_clock u_clock (.clk(clk), .reset_reg(reset_reg));

    scratchpad_top #(.ADDR_WIDTH(ADDR_W)) u_scratchpad_top (
        .clk(clk), .reset_reg(reset_reg),
        .fetch_req_valid(fetch_req_valid), .fetch_req_ready(fetch_req_ready),
        .fetch_req(fetch_req),
        .fetch_resp_valid(fetch_resp_valid), .fetch_resp_ready(fetch_resp_ready),
        .fetch_resp(fetch_resp),
        .data_req_valid(data_req_valid), .data_req_ready(data_req_ready),
        .data_req(data_req),
        .data_resp_valid(data_resp_valid), .data_resp_ready(data_resp_ready),
        .data_resp(data_resp)
    );

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], lfsr[0]};
            lfsr  = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
        end
        return value;
    endfunction

    function automatic data_req_t make_req(input byte_addr_t addr, input logic write,
                                           input access_size_e size, input logic is_unsigned,
                                           input word_t wdata);
        return {addr, write, size, is_unsigned, wdata};
    endfunction

    function automatic data_req_t random_req();
        byte_addr_t   addr;
        logic [1:0]   pick;
        access_size_e size;
        logic         write;
        logic         is_unsigned;
        addr        = byte_addr_t'(rand_bits(16));
        pick        = rand_bits(2);
        write       = rand_bits(1);
        is_unsigned = rand_bits(1);
        size = (pick == 2'd0) ? SIZE_BYTE : (pick == 2'd1) ? SIZE_HALF : SIZE_WORD;
        if (size == SIZE_HALF) addr[0] = 1'b0;
        if (size == SIZE_WORD) addr[1:0] = 2'b00;
        return make_req(addr, write, size, is_unsigned, rand_bits(32));
    endfunction

    // reference memory, upper address bits wrap
    function automatic word_t model_word(input byte_addr_t addr);
        word_t w;
        int    base;
        base = {addr[ADDR_W+1:2], 2'b00};
        for (int i = 0; i < 4; i++) begin
            w[8*i +: 8] = model_mem[base + i];
        end
        return w;
    endfunction

    function automatic void model_store(input data_req_t req);
        int n;
        n = (req.size == SIZE_BYTE) ? 1 : (req.size == SIZE_HALF) ? 2 : 4;
        for (int i = 0; i < n; i++) begin
            model_mem[req.addr[ADDR_W+1:0] + i] = req.wdata[8*i +: 8];
        end
    endfunction

    // addressed bytes moved down, then extended to a word
    function automatic word_t expect_load(input data_req_t req);
        word_t shifted;
        word_t mask;
        int    bits;
        bits    = (req.size == SIZE_BYTE) ? 8 : (req.size == SIZE_HALF) ? 16 : 32;
        shifted = model_word(req.addr) >> (8 * req.addr[1:0]);
        if (bits == 32) return shifted;
        mask    = (32'd1 << bits) - 1;
        shifted = shifted & mask;
        if (!req.is_unsigned && shifted[bits-1]) shifted = shifted | ~mask;
        return shifted;
    endfunction

    task automatic check_value(input string name, input word_t exp, input word_t got);
        assert (got === exp) else begin
            $display("ERROR: %s expected %h got %h", name, exp, got);
            test_errors++;
        end
    endtask

    // one clock: check transfers at the falling edge, drive after the rising edge
    task automatic step_cycle(input logic random_mode);
        logic fetch_fire;
        logic data_fire;
        @(negedge clk);
        fetch_fire = fetch_req_valid && fetch_req_ready;
        data_fire  = data_req_valid && data_req_ready;
        if (fetch_resp_valid && fetch_resp_ready) begin
            assert (fetch_exp.size() != 0) else begin
                $display("fetch channel returned a response with no request outstanding");
                test_errors++;
            end
            if (fetch_exp.size() != 0) check_value("fetch_resp.rdata", fetch_exp.pop_front(),
                                                   fetch_resp.rdata);
        end
        if (data_resp_valid && data_resp_ready) begin
            assert (data_exp.size() != 0) else begin
                $display("data channel returned a response with no request outstanding");
                test_errors++;
            end
            if (data_exp.size() != 0) check_value("data_resp.rdata", data_exp.pop_front(),
                                                  data_resp.rdata);
        end
        assert (!(fetch_fire && data_fire && data_req.write &&
                  fetch_req.addr[ADDR_W+1:2] == data_req.addr[ADDR_W+1:2])) else begin
            $display("fetch accepted in the same cycle as a store to its word");
            test_errors++;
        end
        // no same-word store this cycle, so the fetch sees the current model
        if (fetch_fire) begin
            fetch_exp.push_back(model_word(fetch_req.addr));
            fetch_q.delete(0);
        end
        if (data_fire) begin
            if (data_req.write) model_store(data_req);
            data_exp.push_back(expect_load(data_req));
            data_q.delete(0);
        end
        @(posedge clk);
        #1;
        if (fetch_fire || !fetch_req_valid) begin
            fetch_req_valid = fetch_q.size() != 0 && (!random_mode || rand_bits(2) != 0);
            if (fetch_q.size() != 0) fetch_req.addr = fetch_q[0];
        end
        if (data_fire || !data_req_valid) begin
            data_req_valid = data_q.size() != 0 && (!random_mode || rand_bits(2) != 0);
            if (data_q.size() != 0) data_req = data_q[0];
        end
        fetch_resp_ready = !random_mode || rand_bits(2) != 0;
        data_resp_ready  = !random_mode || rand_bits(2) != 0;
    endtask

    task automatic drain(input logic random_mode);
        do begin
            step_cycle(random_mode);
        end while (fetch_q.size() != 0 || data_q.size() != 0 || fetch_req_valid ||
                   data_req_valid || fetch_exp.size() != 0 || data_exp.size() != 0);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) tests_passed++;
        else tests_failed++;
        $display("%s: done with %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, %0d fetch and %0d data responses missing",
                     cycles, fetch_exp.size(), data_exp.size());
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        foreach (model_mem[i]) model_mem[i] = '0;
        fetch_req_valid  = 1'b0;
        fetch_req        = '0;
        fetch_resp_ready = 1'b1;
        data_req_valid   = 1'b0;
        data_req         = '0;
        data_resp_ready  = 1'b1;

        wait (reset_reg === 1'b0);
        @(negedge clk);
        check_value("fetch_resp_valid", 32'(0), 32'(fetch_resp_valid));
        check_value("data_resp_valid", 32'(0), 32'(data_resp_valid));
        check_value("fetch_req_ready", 32'(1), 32'(fetch_req_ready));
        check_value("data_req_ready", 32'(1), 32'(data_req_ready));
        finish_test("reset");

        // fetch collides with the store and comes back with the new word
        data_q.push_back(make_req(16'h0010, 1'b1, SIZE_WORD, 1'b0, 32'hdeadbeef));
        data_q.push_back(make_req(16'h0010, 1'b0, SIZE_WORD, 1'b0, '0));
        fetch_q.push_back(16'h0010);
        drain(1'b0);
        finish_test("word store and reads");

        data_q.push_back(make_req(16'h0020, 1'b1, SIZE_WORD, 1'b0, 32'h11223344));
        data_q.push_back(make_req(16'h0021, 1'b1, SIZE_BYTE, 1'b0, 32'h000000a5));
        data_q.push_back(make_req(16'h0022, 1'b1, SIZE_HALF, 1'b0, 32'h0000beef));
        data_q.push_back(make_req(16'h0020, 1'b0, SIZE_WORD, 1'b0, '0));
        drain(1'b0);
        finish_test("sub-word stores");

        // word at 0x20 now mixes positive and negative lanes
        for (int i = 0; i < 8; i++) begin
            data_q.push_back(make_req(16'h0020 + i / 2, 1'b0, SIZE_BYTE, i[0], '0));
        end
        for (int i = 0; i < 4; i++) begin
            data_q.push_back(make_req(16'h0020 + 2 * (i / 2), 1'b0, SIZE_HALF, i[0], '0));
        end
        drain(1'b0);
        finish_test("load extension");

        // odd rounds fetch through an aliased address
        for (int i = 0; i < 4; i++) begin
            data_q.push_back(make_req(16'h0040 + 4 * i, 1'b1, SIZE_WORD, 1'b0, rand_bits(32)));
            fetch_q.push_back((16'h0040 + 4 * i) ^ (i[0] ? 16'h0100 : 16'h0000));
            drain(1'b0);
        end
        finish_test("collisions");

        for (int i = 0; i < RANDOM_REQS; i++) begin
            fetch_q.push_back(byte_addr_t'(rand_bits(16)) & 16'hfffc);
            data_q.push_back(random_req());
        end
        drain(1'b1);
        finish_test("random traffic");

        $display("summary: %0d passed, %0d failed", tests_passed, tests_failed);
        if (tests_failed == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/10ps

module tb_clock (
    output logic clk,
    output logic reset_reg
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset held over the first three rising edges
    initial begin
        reset_reg = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset_reg = 1'b0;
    end

endmodule

//--- src/scratchpad_top.sv
`timescale 1ns/10ps

module scratchpad_top
    import scratchpad_pkg::*;
#(
    parameter int ADDR_WIDTH = 10
) (
    input  logic       clk,
    input  logic       reset_reg,

    input  logic       fetch_req_valid,
    output logic       fetch_req_ready,
    input  fetch_req_t fetch_req,

    output logic       fetch_resp_valid,
    input  logic       fetch_resp_ready,
    output resp_t      fetch_resp,

    input  logic       data_req_valid,
    output logic       data_req_ready,
    input  data_req_t  data_req,

    output logic       data_resp_valid,
    input  logic       data_resp_ready,
    output resp_t      data_resp
);

    logic                  mem_en;
    logic                  data_accept;
    logic [ADDR_WIDTH-1:0] fetch_word;
    logic [ADDR_WIDTH-1:0] data_word;
    byte_addr_t            fetch_wrapped;
    byte_addr_t            data_wrapped;
    data_req_t             store_req;
    strb_t                 store_en;
    word_t                 store_data;
    word_t                 fetch_rdata;
    word_t                 data_raw;
    word_t                 data_rdata;

    assign fetch_word = fetch_req.addr[ADDR_WIDTH+1:2];
    assign data_word  = data_req.addr[ADDR_WIDTH+1:2];

    // ignored upper bits dropped, so aliased addresses collide too
    assign fetch_wrapped = byte_addr_t'({fetch_word, 2'b00});
    assign data_wrapped  = byte_addr_t'({data_word, 2'b00});

    // only an accepted store may write
    always_comb begin
        store_req       = data_req;
        store_req.write = data_req.write && data_accept;
    end

    scratchpad_ctrl u_ctrl (
        .clk              (clk),
        .reset_reg        (reset_reg),
        .fetch_req_valid  (fetch_req_valid),
        .data_req_valid   (data_req_valid),
        .fetch_addr       (fetch_wrapped),
        .data_addr        (data_wrapped),
        .data_write       (data_req.write),
        .fetch_resp_ready (fetch_resp_ready),
        .data_resp_ready  (data_resp_ready),
        .fetch_req_ready  (fetch_req_ready),
        .data_req_ready   (data_req_ready),
        .fetch_resp_valid (fetch_resp_valid),
        .data_resp_valid  (data_resp_valid),
        .mem_en           (mem_en),
        .data_accept      (data_accept)
    );

    store_align u_store (
        .clk      (clk),
        .valid    (data_req_valid),
        .req      (store_req),
        .write_en (store_en),
        .wdata    (store_data)
    );

    load_align u_load (
        .clk       (clk),
        .reset_reg (reset_reg),
        .capture   (data_accept),
        .req       (data_req),
        .raw       (data_raw),
        .rdata     (data_rdata)
    );

    // port 1 serves the fetch channel and is read-only
    dual_port_bram #(
        .ADDR_WIDTH (ADDR_WIDTH)
    ) u_bram (
        .clk        (clk),
        .reset_reg  (reset_reg),
        .en         (mem_en),
        .write_en_1 ('0),
        .addr_1     (fetch_word),
        .data_in_1  ('0),
        .data_out_1 (fetch_rdata),
        .write_en_2 (store_en),
        .addr_2     (data_word),
        .data_in_2  (store_data),
        .data_out_2 (data_raw)
    );

    assign fetch_resp.rdata = fetch_rdata;
    assign data_resp.rdata  = data_rdata;

endmodule

//--- src/scratchpad_ctrl.sv
`timescale 1ns/10ps

module scratchpad_ctrl
    import scratchpad_pkg::*;
(
    input  logic       clk,
    input  logic       reset_reg,

    input  logic       fetch_req_valid,
    input  logic       data_req_valid,
    input  byte_addr_t fetch_addr,
    input  byte_addr_t data_addr,
    input  logic       data_write,
    input  logic       fetch_resp_ready,
    input  logic       data_resp_ready,

    output logic       fetch_req_ready,
    output logic       data_req_ready,
    output logic       fetch_resp_valid,
    output logic       data_resp_valid,
    output logic       mem_en,
    output logic       data_accept
);

    logic collision;
    logic fetch_accept;

    // any stalled response freezes both channels
    assign mem_en = !(fetch_resp_valid && !fetch_resp_ready) &&
                    !(data_resp_valid && !data_resp_ready);

    // store to the fetched word goes first
    assign collision = data_req_valid && data_write &&
                       (fetch_addr[15:2] == data_addr[15:2]);

    assign data_req_ready  = mem_en;
    assign fetch_req_ready = mem_en && !collision;

    assign fetch_accept = fetch_req_valid && fetch_req_ready;
    assign data_accept  = data_req_valid && data_req_ready;

    always_ff @(posedge clk) begin
        if (reset_reg) begin
            fetch_resp_valid <= 1'b0;
        end else if (fetch_accept) begin
            fetch_resp_valid <= 1'b1;
        end else if (fetch_resp_ready) begin
            fetch_resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_reg) begin
            data_resp_valid <= 1'b0;
        end else if (data_accept) begin
            data_resp_valid <= 1'b1;
        end else if (data_resp_ready) begin
            data_resp_valid <= 1'b0;
        end
    end

    // stalled responses stay up
    assert property (@(posedge clk) disable iff (reset_reg)
        fetch_resp_valid && !fetch_resp_ready |=> fetch_resp_valid)
        else $error("scratchpad_ctrl: fetch response dropped without ready");

    assert property (@(posedge clk) disable iff (reset_reg)
        data_resp_valid && !data_resp_ready |=> data_resp_valid)
        else $error("scratchpad_ctrl: data response dropped without ready");

    assert property (@(posedge clk) disable iff (reset_reg)
        fetch_accept && data_accept && data_write |->
            fetch_addr[15:2] != data_addr[15:2])
        else $error("scratchpad_ctrl: fetch accepted during store to %0h", data_addr);

endmodule

//--- src/load_align.sv
`timescale 1ns/10ps

module load_align
    import scratchpad_pkg::*;
(
    input  logic      clk,
    input  logic      reset_reg,
    input  logic      capture,
    input  data_req_t req,
    input  word_t     raw,
    output word_t     rdata
);

    logic [1:0]   offset_q;
    access_size_e size_q;
    logic         unsigned_q;

    byte_t        sel_byte;
    logic [15:0]  sel_half;
    logic         byte_sign;
    logic         half_sign;

    // shape of the access whose word arrives next cycle
    always_ff @(posedge clk) begin
        if (reset_reg) begin
            offset_q   <= '0;
            size_q     <= SIZE_WORD;
            unsigned_q <= 1'b0;
        end else if (capture) begin
            offset_q   <= req.addr[1:0];
            size_q     <= req.size;
            unsigned_q <= req.is_unsigned;
        end
    end

    assign sel_byte  = raw[8*offset_q +: 8];
    assign sel_half  = offset_q[1] ? raw[31:16] : raw[15:0];
    assign byte_sign = !unsigned_q && sel_byte[7];
    assign half_sign = !unsigned_q && sel_half[15];

    always_comb begin
        case (size_q)
            SIZE_BYTE: rdata = {{(DATA_WIDTH - 8){byte_sign}}, sel_byte};
            SIZE_HALF: rdata = {{(DATA_WIDTH - 16){half_sign}}, sel_half};
            default:   rdata = raw;
        endcase
    end

endmodule

//--- src/store_align.sv
`timescale 1ns/10ps

module store_align
    import scratchpad_pkg::*;
(
    input  logic      clk,
    input  logic      valid,
    input  data_req_t req,
    output strb_t     write_en,
    output word_t     wdata
);

    logic [1:0] offset;
    strb_t      lane_strb;

    assign offset = req.addr[1:0];

    // replicate the low bits across the word, strobes pick the lane
    always_comb begin
        case (req.size)
            SIZE_BYTE: begin
                wdata     = {BYTES_PER_WORD{req.wdata[7:0]}};
                lane_strb = strb_t'(1) << offset;
            end
            SIZE_HALF: begin
                wdata     = {(BYTES_PER_WORD / 2){req.wdata[15:0]}};
                lane_strb = strb_t'(3) << offset;
            end
            SIZE_WORD: begin
                wdata     = req.wdata;
                lane_strb = '1;
            end
            default: begin
                wdata     = req.wdata;
                lane_strb = '0;
            end
        endcase
    end

    assign write_en = req.write ? lane_strb : '0;

    assert property (@(posedge clk)
        valid |-> (req.size == SIZE_BYTE) ||
                  (req.size == SIZE_HALF && !req.addr[0]) ||
                  (req.size == SIZE_WORD && req.addr[1:0] == 2'b00))
        else $error("store_align: misaligned access at %0h", req.addr);

endmodule

//--- src/dual_port_bram.sv
`timescale 1ns/10ps

module dual_port_bram
    import scratchpad_pkg::*;
#(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                  clk,
    input  logic                  reset_reg,
    input  logic                  en,

    // port 1
    input  strb_t                 write_en_1,
    input  logic [ADDR_WIDTH-1:0] addr_1,
    input  word_t                 data_in_1,
    output word_t                 data_out_1,

    // port 2
    input  strb_t                 write_en_2,
    input  logic [ADDR_WIDTH-1:0] addr_2,
    input  word_t                 data_in_2,
    output word_t                 data_out_2
);

    localparam int NUM_WORDS = 2 ** ADDR_WIDTH;

    // contents start cleared in simulation
    byte_t [BYTES_PER_WORD-1:0] mem [NUM_WORDS] = '{default: '0};

    byte_t [BYTES_PER_WORD-1:0] merged_1;
    byte_t [BYTES_PER_WORD-1:0] merged_2;

    // new word per port, enabled lanes replaced
    always_comb begin
        for (int i = 0; i < BYTES_PER_WORD; i++) begin
            merged_1[i] = write_en_1[i] ? data_in_1[8*i +: 8] : mem[addr_1][i];
            merged_2[i] = write_en_2[i] ? data_in_2[8*i +: 8] : mem[addr_2][i];
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            if (|write_en_1) begin
                mem[addr_1] <= merged_1;
            end
            if (|write_en_2) begin
                mem[addr_2] <= merged_2;
            end
        end
    end

    // write-first: output sees the merged word
    always_ff @(posedge clk) begin
        if (reset_reg) begin
            data_out_1 <= '0;
            data_out_2 <= '0;
        end else if (en) begin
            data_out_1 <= merged_1;
            data_out_2 <= merged_2;
        end
    end

    // both ports writing one word leaves the result undefined
    assert property (@(posedge clk) disable iff (reset_reg)
        en && (addr_1 == addr_2) |-> !((|write_en_1) && (|write_en_2)))
        else $error("dual_port_bram: both ports write word %0h", addr_1);

endmodule

//--- src/scratchpad_pkg.sv
package scratchpad_pkg;

    // memory word geometry
    localparam int DATA_WIDTH     = 32;
    localparam int BYTES_PER_WORD = 4;

    typedef logic [7:0]                byte_t;
    typedef logic [DATA_WIDTH-1:0]     word_t;
    typedef logic [BYTES_PER_WORD-1:0] strb_t;

    // byte address on the channels, bits 1:0 pick the lane
    typedef logic [15:0] byte_addr_t;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } access_size_e;

    // fetch channel request, aligned words only
    typedef struct packed {
        byte_addr_t addr;
    } fetch_req_t;

    // load/store request, wdata is right-aligned
    typedef struct packed {
        byte_addr_t   addr;
        logic         write;
        access_size_e size;
        logic         is_unsigned;
        word_t        wdata;
    } data_req_t;

    typedef struct packed {
        word_t rdata;
    } resp_t;

endpackage
